// ==== codec_pkg.sv ====
`default_nettype none

package codec_pkg;

    ////////////////////////////////////////
    // Modulus arithmetic
    ////////////////////////////////////////

    // Prime modulus of the coefficient ring
    localparam int MODULUS = 3329;

    // Rounding offset, half the modulus
    localparam int MODULUS_HALF = 1664;

    // Fixed-point reciprocal of the modulus, scaled by 2^INV_SHIFT
    localparam int unsigned MODULUS_INV = 1290167;
    localparam int INV_SHIFT = 32;

    ////////////////////////////////////////
    // Block geometry
    ////////////////////////////////////////

    // Coefficients per polynomial block
    localparam int BLOCK_COEFFS = 256;

    // Widest packed field, d = 12 is the uncompressed case
    localparam int MAX_WIDTH = 12;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Signed input coefficient, also carries a packed field
    typedef logic signed [15:0] coeff_t;

    // Field width d, legal range 1 to 12
    typedef logic [3:0] width_t;

    // One byte of the packed output stream
    typedef logic [7:0] byte_t;

    // Position of a coefficient inside its block
    typedef logic [$clog2(BLOCK_COEFFS)-1:0] coeff_idx_t;

endpackage

`default_nettype wire

// ==== coeff_stream_if.sv ====
`default_nettype none

// Compressed coefficient stream, one field per transfer
interface coeff_stream_if;

    logic               valid;
    logic               ready;
    codec_pkg::coeff_t  field;
    codec_pkg::width_t  width;
    // High on the final field of a block
    logic               last;

    // Producer side
    modport source (
        output valid,
        output field,
        output width,
        output last,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid,
        input  field,
        input  width,
        input  last,
        output ready
    );

endinterface

`default_nettype wire

// ==== coeff_compress.sv ====
`default_nettype none

module coeff_compress (
    input  wire                     clk,
    input  wire                     rst,
    input  wire codec_pkg::width_t  width_i,
    input  wire                     compress_en_i,
    input  wire                     in_valid_i,
    output logic                    in_ready_o,
    input  wire codec_pkg::coeff_t  in_coeff_i,
    coeff_stream_if.source          out_o
);

    // Pipeline handshake
    logic                   advance;
    logic                   accept;

    // Stage 1 combinational
    logic [15:0]            norm;
    logic [27:0]            comp_form;
    logic                   use_plain;
    codec_pkg::coeff_idx_t  coeff_cnt;

    // Stage 1 registers
    logic                   s1_valid;
    logic [27:0]            s1_form;
    logic                   s1_plain;
    codec_pkg::width_t      s1_width;
    logic                   s1_last;

    // Stage 2 combinational
    logic [63:0]            product;
    logic [27:0]            approx;
    logic [27:0]            approx_rem;
    logic [15:0]            quotient;
    logic [15:0]            mask;

    // Stage 2 registers, visible on the stream
    logic                   s2_valid;
    codec_pkg::coeff_t      s2_field;
    codec_pkg::width_t      s2_width;
    logic                   s2_last;

    // Both stages move together whenever stage 2 can hand off
    assign advance    = !s2_valid || out_o.ready;
    assign in_ready_o = advance;
    assign accept     = in_valid_i && advance;

    ////////////////////////////////////////
    // Stage 1 normalize and scale
    ////////////////////////////////////////

    // Fold negative residues into [0, Q)
    assign norm = in_coeff_i[15] ? in_coeff_i + 16'(codec_pkg::MODULUS) : in_coeff_i;

    // One extra count absorbs the truncation error of the reciprocal
    assign comp_form = (28'(norm) << width_i) + 28'(codec_pkg::MODULUS_HALF + 1);

    // d = 12 bypasses rounding entirely
    assign use_plain = !compress_en_i ||
                       (width_i == codec_pkg::width_t'(codec_pkg::MAX_WIDTH));

    always_ff @(posedge clk) begin
        if (!rst) begin
            s1_valid  <= 1'b0;
            coeff_cnt <= '0;
        end else begin
            if (accept) begin
                coeff_cnt <= coeff_cnt + codec_pkg::coeff_idx_t'(1);
            end
            if (advance) begin
                s1_valid <= in_valid_i;
            end
        end
    end

    // Width and mode ride along with each item
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_form  <= use_plain ? 28'(norm) : comp_form;
            s1_plain <= use_plain;
            s1_width <= width_i;
            s1_last  <= (coeff_cnt == codec_pkg::coeff_idx_t'(codec_pkg::BLOCK_COEFFS - 1));
        end
    end

    ////////////////////////////////////////
    // Stage 2 divide and mask
    ////////////////////////////////////////

    // Divide by Q through multiply and shift
    assign product = 64'(s1_form) * 64'(codec_pkg::MODULUS_INV);
    assign approx  = 28'(product >> codec_pkg::INV_SHIFT);

    // At d = 11 an exact multiple of Q can still come out one short
    assign approx_rem = s1_form - approx * 28'(codec_pkg::MODULUS);
    assign quotient   = s1_plain ? 16'(s1_form) :
                        16'((approx_rem > 28'(codec_pkg::MODULUS)) ? approx + 28'd1 : approx);

    // Keep the low d bits for the mod 2^d step
    assign mask = (16'd1 << s1_width) - 16'd1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_field <= codec_pkg::coeff_t'(quotient & mask);
            s2_width <= s1_width;
            s2_last  <= s1_last;
        end
    end

    assign out_o.valid = s2_valid;
    assign out_o.field = s2_field;
    assign out_o.width = s2_width;
    assign out_o.last  = s2_last;

endmodule

`default_nettype wire

// ==== bit_packer.sv ====
`default_nettype none

module bit_packer (
    input  wire                 clk,
    input  wire                 rst,
    coeff_stream_if.sink        in_i,
    output logic                byte_valid_o,
    input  wire                 byte_ready_i,
    output codec_pkg::byte_t    byte_o,
    output logic                byte_last_o
);

    // Pending bits, LSB is the next bit out
    logic [23:0]    acc;

    // Number of valid bits in acc, at most 7 + 12
    logic [4:0]     pend_cnt;

    // Last field of the block is inside acc
    logic           last_seen;

    logic           take;
    logic           put;
    logic [23:0]    field_ext;
    logic           final_byte;

    ////////////////////////////////////////
    // Handshakes
    ////////////////////////////////////////

    // Room for a new field only below one full byte
    assign in_i.ready   = (pend_cnt < 5'd8);

    // A byte is ready once eight bits are pending
    assign byte_valid_o = (pend_cnt >= 5'd8);

    assign take = byte_valid_o && byte_ready_i;
    assign put  = in_i.valid && in_i.ready;

    ////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////

    // Only the low field bits are ever meaningful
    assign field_ext = 24'(in_i.field[codec_pkg::MAX_WIDTH-1:0]);

    // New field lands just above the pending bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            acc <= '0;
        end else if (take) begin
            acc <= acc >> 8;
        end else if (put) begin
            acc <= acc | (field_ext << pend_cnt);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pend_cnt <= '0;
        end else if (take) begin
            pend_cnt <= pend_cnt - 5'd8;
        end else if (put) begin
            pend_cnt <= pend_cnt + 5'(in_i.width);
        end
    end

    ////////////////////////////////////////
    // Block end tracking
    ////////////////////////////////////////

    // This byte drains the accumulator completely
    assign final_byte = (pend_cnt == 5'd8);

    // 256 * d is a multiple of 8, so the block always ends on a byte edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            last_seen <= 1'b0;
        end else if (take && final_byte) begin
            last_seen <= 1'b0;
        end else if (put && in_i.last) begin
            last_seen <= 1'b1;
        end
    end

    assign byte_o      = acc[7:0];
    assign byte_last_o = last_seen && final_byte;

endmodule

`default_nettype wire

// ==== byte_encode_top.sv ====
`default_nettype none

module byte_encode_top (
    input  wire                     clk,
    input  wire                     rst,

    // Block configuration, held for a whole block
    input  wire codec_pkg::width_t  width_i,
    input  wire                     compress_en_i,

    // Coefficient input stream
    input  wire                     coeff_valid_i,
    output logic                    coeff_ready_o,
    input  wire codec_pkg::coeff_t  coeff_i,

    // Packed byte output stream
    output logic                    byte_valid_o,
    input  wire                     byte_ready_i,
    output codec_pkg::byte_t        byte_o,
    output logic                    byte_last_o
);

    // Compressed fields between the two stages
    coeff_stream_if coeff_if ();

    // Normalize, round and mask each coefficient
    coeff_compress u_coeff_compress (
        .clk            (clk),
        .rst            (rst),
        .width_i        (width_i),
        .compress_en_i  (compress_en_i),
        .in_valid_i     (coeff_valid_i),
        .in_ready_o     (coeff_ready_o),
        .in_coeff_i     (coeff_i),
        .out_o          (coeff_if.source)
    );

    // Pack d-bit fields LSB first into bytes
    bit_packer u_bit_packer (
        .clk            (clk),
        .rst            (rst),
        .in_i           (coeff_if.sink),
        .byte_valid_o   (byte_valid_o),
        .byte_ready_i   (byte_ready_i),
        .byte_o         (byte_o),
        .byte_last_o    (byte_last_o)
    );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     coeff_valid_i,
    input  wire                     coeff_ready_i,
    input  wire codec_pkg::coeff_t  coeff_i,
    input  wire codec_pkg::width_t  width_i,
    input  wire                     compress_en_i,
    input  wire                     byte_valid_i,
    input  wire                     byte_ready_i,
    input  wire codec_pkg::byte_t   byte_i,
    input  wire                     byte_last_i,
    output int                      error_count_o,
    output int                      blocks_done_o,
    output int                      bytes_seen_o,
    output int                      pending_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Expected byte stream with its last flags
    codec_pkg::byte_t   exp_bytes[$];
    bit                 exp_last[$];
    // Expected byte count of each block, 32 * d
    int                 block_len[$];

    // Model bit stream, LSB is the next bit out
    longint             model_bits;
    int                 model_cnt;
    int                 coeff_idx;
    int                 byte_in_block;

    // Output held while stalled
    bit                 was_stalled;
    codec_pkg::byte_t   stalled_byte;
    bit                 stalled_last;

    // First cycle out of reset is still ahead
    bit                 reset_seen;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Normalize, then round to d bits or just mask
    function automatic int ref_field(input int coeff, input int d, input bit en);
        int     x;
        longint scaled;
        x = coeff % codec_pkg::MODULUS;
        if (x < 0) begin
            x = x + codec_pkg::MODULUS;
        end
        if (!en || d == codec_pkg::MAX_WIDTH) begin
            return x & ((1 << d) - 1);
        end
        scaled = (longint'(x) << d) + codec_pkg::MODULUS_HALF;
        return int'(scaled / codec_pkg::MODULUS) & ((1 << d) - 1);
    endfunction

    // Fields go in LSB first, whole bytes come out
    task automatic append_field(input int f, input int d, input bit block_end);
        model_bits = model_bits | (longint'(f) << model_cnt);
        model_cnt  = model_cnt + d;
        while (model_cnt >= 8) begin
            exp_bytes.push_back(codec_pkg::byte_t'(model_bits[7:0]));
            exp_last.push_back(block_end && model_cnt == 8);
            model_bits = model_bits >> 8;
            model_cnt  = model_cnt - 8;
        end
    endtask

    task automatic check_byte();
        codec_pkg::byte_t   want;
        bit                 want_last;
        int                 want_len;
        if (exp_bytes.size() == 0) begin
            $display("Unexpected output byte 0x%02h at time %0t, the model has no byte left",
                     byte_i, $time);
            error_count_o++;
        end else begin
            want      = exp_bytes.pop_front();
            want_last = exp_last.pop_front();
            if (byte_i !== want || byte_last_i !== want_last) begin
                $display({"[ERROR] %0t: byte %0d of block is 0x%02h last %0b, ",
                          "expected 0x%02h last %0b"},
                         $time, byte_in_block, byte_i, byte_last_i, want, want_last);
                error_count_o++;
            end
        end
        bytes_seen_o++;
        byte_in_block++;
        if (byte_last_i) begin
            want_len = (block_len.size() > 0) ? block_len.pop_front() : -1;
            if (byte_in_block != want_len) begin
                $display("[ERROR] %0t: last flag on byte %0d of block, expected on byte %0d",
                         $time, byte_in_block, want_len);
                error_count_o++;
            end
            blocks_done_o++;
            byte_in_block = 0;
        end
    endtask

    ////////////////////////////////////////
    // Monitor and compare
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            exp_bytes.delete();
            exp_last.delete();
            block_len.delete();
            model_bits    = 0;
            model_cnt     = 0;
            coeff_idx     = 0;
            byte_in_block = 0;
            was_stalled   = 1'b0;
            reset_seen    = 1'b1;
            error_count_o = 0;
            blocks_done_o = 0;
            bytes_seen_o  = 0;
            pending_o     = 0;
        end else begin
            // Idle handshake right after reset release
            if (reset_seen && (!coeff_ready_i || byte_valid_i || byte_last_i)) begin
                $display("[ERROR] %0t: after reset ready %0b valid %0b last %0b, expected 1 0 0",
                         $time, coeff_ready_i, byte_valid_i, byte_last_i);
                error_count_o++;
            end
            reset_seen = 1'b0;
            if (coeff_valid_i && coeff_ready_i) begin
                if (coeff_idx == 0) begin
                    block_len.push_back(32 * int'(width_i));
                end
                append_field(ref_field(int'(coeff_i), int'(width_i), compress_en_i),
                             int'(width_i), coeff_idx == codec_pkg::BLOCK_COEFFS - 1);
                coeff_idx = (coeff_idx == codec_pkg::BLOCK_COEFFS - 1) ? 0 : coeff_idx + 1;
            end
            // A stalled byte must stay put until taken
            if (was_stalled && (!byte_valid_i || byte_i !== stalled_byte ||
                                byte_last_i !== stalled_last)) begin
                $display("Output byte changed or dropped at time %0t before it was taken",
                         $time);
                error_count_o++;
            end
            if (byte_valid_i && byte_ready_i) begin
                check_byte();
            end
            was_stalled  = byte_valid_i && !byte_ready_i;
            stalled_byte = byte_i;
            stalled_last = byte_last_i;
            pending_o    = exp_bytes.size();
        end
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED = 32'heed6ca5f;
    localparam int READY_LIMIT = 1000;
    localparam int BLOCK_LIMIT = 20000;

    logic                   clk = 1'b0;
    logic                   rst;
    codec_pkg::width_t      width;
    logic                   compress_en;
    logic                   coeff_valid;
    logic                   coeff_ready;
    codec_pkg::coeff_t      coeff;
    logic                   byte_valid;
    logic                   byte_ready = 1'b1;
    codec_pkg::byte_t       byte_data;
    logic                   byte_last;

    int                     error_count;
    int                     blocks_done;
    int                     bytes_seen;
    int                     pending;

    int unsigned            stim_rng;
    int unsigned            ready_rng;
    bit                     stall_en;
    bit                     timed_out;
    int                     blocks_sent;
    int                     test_num;
    int                     tests_passed;
    int                     tests_failed;
    int                     errors_mark;
    int                     bytes_mark;

    always #10 clk = ~clk;

    byte_encode_top u_byte_encode_top (
        .clk            (clk),
        .rst            (rst),
        .width_i        (width),
        .compress_en_i  (compress_en),
        .coeff_valid_i  (coeff_valid),
        .coeff_ready_o  (coeff_ready),
        .coeff_i        (coeff),
        .byte_valid_o   (byte_valid),
        .byte_ready_i   (byte_ready),
        .byte_o         (byte_data),
        .byte_last_o    (byte_last)
    );

    tb_checker u_tb_checker (
        .clk            (clk),
        .rst            (rst),
        .coeff_valid_i  (coeff_valid),
        .coeff_ready_i  (coeff_ready),
        .coeff_i        (coeff),
        .width_i        (width),
        .compress_en_i  (compress_en),
        .byte_valid_i   (byte_valid),
        .byte_ready_i   (byte_ready),
        .byte_i         (byte_data),
        .byte_last_i    (byte_last),
        .error_count_o  (error_count),
        .blocks_done_o  (blocks_done),
        .bytes_seen_o   (bytes_seen),
        .pending_o      (pending)
    );

    function automatic int unsigned lcg_next(input int unsigned state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Uniform in [-3328, 3328]
    function automatic int rand_coeff();
        stim_rng = lcg_next(stim_rng);
        return int'((stim_rng >> 8) % 32'd6657) - 3328;
    endfunction

    // Rounding edges 0, Q/2, Q/2 + 1, Q - 1 and -1
    function automatic int edge_coeff(input int idx);
        case (idx)
            0:       return 0;
            1:       return 1664;
            2:       return 1665;
            3:       return 3328;
            default: return -1;
        endcase
    endfunction

    // Random output back-pressure, ready on about 40 percent of cycles
    always @(negedge clk) begin
        if (stall_en) begin
            ready_rng  = lcg_next(ready_rng);
            byte_ready = ((ready_rng >> 8) % 32'd10) < 32'd4;
        end else begin
            byte_ready = 1'b1;
        end
    end

    // Later steps are skipped once a wait has run out
    task automatic report_timeout(input string reason);
        $display("%s", reason);
        timed_out = 1'b1;
    endtask

    ////////////////////////////////////////
    // Stimulus and test flow
    ////////////////////////////////////////

    // Called on a falling edge, returns on one
    task automatic send_block(input int d, input bit en, input int n_edges, input bit hold_valid);
        int idx;
        int waited;
        bit taken;
        if (timed_out) begin
            return;
        end
        for (idx = 0; idx < codec_pkg::BLOCK_COEFFS; idx++) begin
            coeff_valid = 1'b1;
            coeff       = codec_pkg::coeff_t'((idx < n_edges) ? edge_coeff(idx) : rand_coeff());
            width       = codec_pkg::width_t'(d);
            compress_en = en;
            taken       = 1'b0;
            waited      = 0;
            // Ready only moves on rising edges
            while (!taken && waited < READY_LIMIT) begin
                taken = coeff_ready;
                @(negedge clk);
                waited++;
            end
            if (!taken) begin
                report_timeout("Coefficient input was never accepted, coeff_ready_o stuck low");
                return;
            end
        end
        if (!hold_valid) begin
            coeff_valid = 1'b0;
        end
        blocks_sent++;
    endtask

    task automatic wait_blocks();
        int waited;
        if (timed_out) begin
            return;
        end
        waited = 0;
        while (blocks_done < blocks_sent && waited < BLOCK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (blocks_done < blocks_sent) begin
            report_timeout("Timed out waiting for the last byte of a block");
        end
    endtask

    task automatic finish_test(input string name, input int want_bytes);
        int errs;
        int got_bytes;
        if (timed_out) begin
            return;
        end
        errs      = error_count - errors_mark;
        got_bytes = bytes_seen - bytes_mark;
        if (errs == 0 && got_bytes == want_bytes && pending == 0) begin
            tests_passed++;
            $display("test %0d (%s) PASS, %0d bytes", test_num, name, got_bytes);
        end else begin
            tests_failed++;
            $display("test %0d (%s) FAIL, %0d errors, %0d of %0d bytes, %0d bytes missing",
                     test_num, name, errs, got_bytes, want_bytes, pending);
        end
        errors_mark = error_count;
        bytes_mark  = bytes_seen;
        test_num++;
    endtask

    initial begin
        rst          = 1'b0;
        width        = 4'd12;
        compress_en  = 1'b0;
        coeff_valid  = 1'b0;
        coeff        = '0;
        stim_rng     = SEED;
        ready_rng    = lcg_next(SEED);
        stall_en     = 1'b0;
        timed_out    = 1'b0;
        blocks_sent  = 0;
        test_num     = 1;
        tests_passed = 0;
        tests_failed = 0;
        errors_mark  = 0;
        bytes_mark   = 0;
        repeat (3) @(negedge clk);
        rst = 1'b1;

        send_block(12, 1'b0, 0, 1'b0);
        wait_blocks();
        finish_test("d=12 uncompressed", 384);

        send_block(4, 1'b1, 5, 1'b0);
        wait_blocks();
        finish_test("d=4 rounding edges", 128);

        send_block(1, 1'b1, 0, 1'b0);
        send_block(10, 1'b1, 0, 1'b0);
        send_block(11, 1'b1, 0, 1'b0);
        wait_blocks();
        finish_test("d=1, 10 and 11", 704);

        stall_en = 1'b1;
        send_block(6, 1'b1, 0, 1'b0);
        send_block(12, 1'b0, 0, 1'b0);
        wait_blocks();
        stall_en = 1'b0;
        finish_test("output back-pressure", 576);

        send_block(3, 1'b1, 0, 1'b0);
        send_block(8, 1'b1, 0, 1'b0);
        send_block(2, 1'b0, 0, 1'b0);
        wait_blocks();
        finish_test("last flag position", 416);

        // Valid stays high across the width change
        send_block(5, 1'b1, 0, 1'b1);
        send_block(9, 1'b1, 0, 1'b0);
        wait_blocks();
        finish_test("back-to-back blocks", 448);

        $display("summary: %0d run, %0d passed, %0d failed, %0d checker errors",
                 test_num - 1, tests_passed, tests_failed, error_count);
        if (!timed_out && tests_failed == 0 && error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
codec_pkg.sv
coeff_stream_if.sv
coeff_compress.sv
bit_packer.sv
byte_encode_top.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the byte encoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -q "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }
